// File: sources.f
ooo_pkg.sv
reorder_buffer.sv
dispatch_stage.sv
functional_unit.sv
retire_stage.sv
ooo_core_top.sv
ooo_core_assert.sv
tb_ooo_core.sv

// File: Makefile
# Verilator build and run of the out-of-order core testbench

TOP := tb_ooo_core
LOG := sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o sim_$(TOP)

# the log decides pass or fail
run: compile
	./obj_dir/sim_$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;

    localparam int clock_period = 4;
    // length of the random stream
    // the second half is sent back to back
    localparam int num_instr = 200;
    // generous cycles per instruction with mul stalls and flush refill
    localparam int worst_cycles = 12;
    localparam int timeout_ns = (num_instr * worst_cycles + 100) * clock_period;

    // one retire outcome in program order
    typedef struct packed {
        ooo_pkg::opcode_t opcode;
        logic [ooo_pkg::reg_bits-1:0] dest;
        logic [ooo_pkg::data_bits-1:0] value;
        int seq;
    } outcome_t;

    logic clock;
    logic reset;
    ooo_pkg::instr_packet_t instr_in;
    logic credit_return;
    ooo_pkg::commit_packet_t commit_out;
    ooo_pkg::store_packet_t store_out;
    logic flush_out;

    outcome_t expected [$];
    integer seed;
    int credits;
    int sent;
    // rob allocations so far
    // one per credit_return pulse
    int granted = 0;
    int traps_flushed = 0;
    int dropped = 0;
    int committed = 0;

    ooo_core_top ooo_core_top_inst (
        .clock(clock),
        .reset(reset),
        .instr_in(instr_in),
        .credit_return(credit_return),
        .commit_out(commit_out),
        .store_out(store_out),
        .flush_out(flush_out)
    );

    //////////////////////////////
    // reference rules
    //////////////////////////////

    function automatic logic [ooo_pkg::data_bits-1:0] expected_value(
        input ooo_pkg::opcode_t op,
        input logic [ooo_pkg::data_bits-1:0] a,
        input logic [ooo_pkg::data_bits-1:0] b
    );
        logic [2*ooo_pkg::data_bits-1:0] product;
        product = {{ooo_pkg::data_bits{1'b0}}, a} * {{ooo_pkg::data_bits{1'b0}}, b};
        case (op)
            ooo_pkg::op_add: return a + b;
            ooo_pkg::op_sub: return a - b;
            ooo_pkg::op_and: return a & b;
            ooo_pkg::op_xor: return a ^ b;
            // low word of the full product
            ooo_pkg::op_mul: return product[ooo_pkg::data_bits-1:0];
            // store address
            ooo_pkg::op_store: return a + b;
            default: return '0;
        endcase
    endfunction

    function automatic logic is_reg_writer(input ooo_pkg::opcode_t op);
        return (op != ooo_pkg::op_store) && (op != ooo_pkg::op_trap);
    endfunction

    task automatic report_mismatch(input string test, input logic [31:0] want,
                                   input logic [31:0] got);
        $display("error: %s expected %h actual %h", test, want, got);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s mismatch", test);
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic make_instr(output ooo_pkg::instr_packet_t pkt);
        logic [31:0] roll;
        roll = $random(seed);
        pkt.valid = 1'b1;
        // about one trap in sixteen
        // muls frequent enough to reorder results
        if (roll[7:4] == 4'd0) begin
            pkt.opcode = ooo_pkg::op_trap;
        end else if (roll[15:14] == 2'd0) begin
            pkt.opcode = ooo_pkg::op_mul;
        end else begin
            pkt.opcode = ooo_pkg::opcode_t'(roll[2:0] % 3'd6);
        end
        pkt.dest = roll[12:8];
        pkt.operand_a = $random(seed);
        pkt.operand_b = $random(seed);
    endtask

    //////////////////////////////
    // output checks
    //////////////////////////////

    task automatic handle_flush();
        outcome_t head;
        assert (expected.size() != 0)
            else report_problem("flush_out pulsed with no instruction outstanding");
        head = expected.pop_front();
        assert (head.opcode == ooo_pkg::op_trap)
            else report_problem("flush_out pulsed but the next instruction is not a trap");
        traps_flushed++;
        // younger instructions already allocated at the flush edge never retire
        while (expected.size() != 0 && expected[0].seq < granted) begin
            expected.delete(0);
            dropped++;
        end
    endtask

    task automatic check_commit();
        outcome_t want;
        assert (expected.size() != 0)
            else report_problem("commit_out fired with no instruction outstanding");
        want = expected.pop_front();
        assert (is_reg_writer(want.opcode))
            else report_problem("commit_out fired where a store or trap was next");
        assert (commit_out.dest == want.dest)
            else report_mismatch("commit_dest", 32'(want.dest), 32'(commit_out.dest));
        assert (commit_out.reg_valid == (want.dest != ooo_pkg::zero_reg))
            else report_mismatch("commit_reg_valid", 32'(want.dest != ooo_pkg::zero_reg),
                                 32'(commit_out.reg_valid));
        // r0 holds no value to compare
        if (want.dest != ooo_pkg::zero_reg) begin
            assert (commit_out.value == want.value)
                else report_mismatch("commit_value", want.value, commit_out.value);
        end
        committed++;
    endtask

    task automatic check_store();
        outcome_t want;
        assert (expected.size() != 0)
            else report_problem("store_out fired with no instruction outstanding");
        want = expected.pop_front();
        assert (want.opcode == ooo_pkg::op_store)
            else report_problem("store_out fired where another instruction was next");
        assert (store_out.address == want.value)
            else report_mismatch("store_address", want.value, store_out.address);
    endtask

    // registered outputs sampled before this edge updates them
    always @(posedge clock) begin
        if (!reset) begin
            if (flush_out) begin
                handle_flush();
            end
            if (commit_out.valid) begin
                check_commit();
            end
            if (store_out.valid) begin
                check_store();
            end
            // counted after the flush since a grant here came after the flush edge
            if (credit_return) begin
                granted++;
            end
        end
    end

    always @(posedge clock) begin
        if (ooo_core_top_inst.ooo_core_assert_inst.failed) begin
            $display("a bound assertion on the core ports failed");
            $display("Simulation finished: FAIL");
            $fatal(1, "bound assertion failure");
        end
    end

    //////////////////////////////
    // clock, stimulus, watchdog
    //////////////////////////////

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin : stimulus
        ooo_pkg::instr_packet_t pkt;
        outcome_t want;
        logic [31:0] gate;
        seed = 4;
        credits = ooo_pkg::queue_depth;
        sent = 0;
        reset = 1'b1;
        instr_in = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        while (sent < num_instr) begin
            @(posedge clock);
            if (credit_return) begin
                credits++;
            end
            gate = $random(seed);
            // gaps in the first half and then every cycle a credit allows
            if (credits > 0 && (sent >= num_instr / 2 || gate[1:0] != 2'd0)) begin
                make_instr(pkt);
                want.opcode = pkt.opcode;
                want.dest = pkt.dest;
                want.value = expected_value(pkt.opcode, pkt.operand_a, pkt.operand_b);
                want.seq = sent;
                expected.push_back(want);
                instr_in <= pkt;
                credits--;
                sent++;
            end else begin
                instr_in <= '0;
            end
        end
        @(posedge clock);
        instr_in <= '0;
        while (expected.size() != 0) begin
            @(posedge clock);
        end
        // quiet tail where any late output has nothing left to match
        repeat (20) @(posedge clock);
        assert (traps_flushed > 0) else report_problem("no trap retired during the run");
        assert (dropped > 0) else report_problem("no trap flushed a younger instruction");
        assert (committed > 0) else report_problem("no register write retired");
        if (ooo_core_top_inst.ooo_core_assert_inst.failed) begin
            $display("a bound assertion on the core ports failed");
            $display("Simulation finished: FAIL");
            $fatal(1, "bound assertion failure");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("timeout, the core did not retire every instruction in %0d ns", timeout_ns);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: ooo_core_assert.sv
`timescale 1ns/1ps

module ooo_core_assert (
    input logic clock,
    input logic reset,
    input ooo_pkg::instr_packet_t instr_in,
    input logic credit_return,
    input ooo_pkg::commit_packet_t commit_out,
    input ooo_pkg::store_packet_t store_out,
    input logic flush_out
);

    localparam int credit_width = ooo_pkg::credit_bits + 1;
    localparam logic [credit_width-1:0] full_credits = credit_width'(ooo_pkg::queue_depth);

    // credits held by the source
    // the spare bit makes an overflow visible
    logic [credit_width-1:0] credits;

    // sticky flags for each assertion group
    bit credit_fail;
    bit reset_fail;
    bit retire_fail;
    bit zero_fail;
    logic failed;

    assign failed = credit_fail | reset_fail | retire_fail | zero_fail;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            credits <= full_credits;
        end else begin
            case ({instr_in.valid, credit_return})
                2'b10: credits <= credits - credit_width'(1);
                2'b01: credits <= credits + credit_width'(1);
                default: credits <= credits;
            endcase
        end
    end

    //////////////////////////////
    // credits
    //////////////////////////////

    // returned credits never outnumber the spent ones
    credit_bound: assert property (@(posedge clock) disable iff (reset)
        credits <= full_credits)
        else begin
            credit_fail = 1'b1;
            $error("credit count above the queue depth");
        end

    //////////////////////////////
    // reset and retire
    //////////////////////////////

    // quiet during reset and on the first cycle after it
    reset_quiet: assert property (@(posedge clock)
        (reset || $past(reset)) |->
            !credit_return && !commit_out.valid && !store_out.valid && !flush_out)
        else begin
            reset_fail = 1'b1;
            $error("output active around reset");
        end

    // one retire outcome per cycle
    one_outcome: assert property (@(posedge clock) disable iff (reset)
        $onehot0({commit_out.valid, store_out.valid, flush_out}))
        else begin
            retire_fail = 1'b1;
            $error("more than one retire outcome in a cycle");
        end

    // flush is a single pulse
    flush_pulse: assert property (@(posedge clock) disable iff (reset)
        flush_out |=> !flush_out)
        else begin
            retire_fail = 1'b1;
            $error("flush_out held for two cycles");
        end

    zero_reg_kept: assert property (@(posedge clock) disable iff (reset)
        commit_out.valid |-> !(commit_out.reg_valid && commit_out.dest == ooo_pkg::zero_reg))
        else begin
            zero_fail = 1'b1;
            $error("commit marks register zero as written");
        end

endmodule

bind ooo_core_top ooo_core_assert ooo_core_assert_inst (
    .clock(clock),
    .reset(reset),
    .instr_in(instr_in),
    .credit_return(credit_return),
    .commit_out(commit_out),
    .store_out(store_out),
    .flush_out(flush_out)
);

// File: ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top (
    input logic clock,
    input logic reset,
    input ooo_pkg::instr_packet_t instr_in,
    output logic credit_return,
    output ooo_pkg::commit_packet_t commit_out,
    output ooo_pkg::store_packet_t store_out,
    output logic flush_out
);

    //////////////////////////////
    // internal wires
    //////////////////////////////

    // dispatch and rob handshake
    logic alloc_req;
    ooo_pkg::opcode_t alloc_opcode;
    logic [ooo_pkg::reg_bits-1:0] alloc_dest;
    logic alloc_grant;
    logic [ooo_pkg::rob_tag_bits-1:0] alloc_tag;

    // execute side
    ooo_pkg::issue_packet_t issue_bus;
    ooo_pkg::result_packet_t result_bus;
    logic fu_ready;

    // retire side
    ooo_pkg::head_packet_t head;
    logic retire_entry;
    logic flush;

    dispatch_stage dispatch_stage_inst (
        .clock(clock),
        .reset(reset),
        .instr_in(instr_in),
        .credit_return(credit_return),
        .fu_ready(fu_ready),
        .alloc_req(alloc_req),
        .alloc_opcode(alloc_opcode),
        .alloc_dest(alloc_dest),
        .alloc_grant(alloc_grant),
        .alloc_tag(alloc_tag),
        .issue_out(issue_bus)
    );

    reorder_buffer reorder_buffer_inst (
        .clock(clock),
        .reset(reset),
        .alloc_req(alloc_req),
        .alloc_opcode(alloc_opcode),
        .alloc_dest(alloc_dest),
        .alloc_grant(alloc_grant),
        .alloc_tag(alloc_tag),
        .result_bus(result_bus),
        .retire_entry(retire_entry),
        .flush(flush),
        .head(head)
    );

    // queue-front opcode doubles as the fu slot lookahead
    functional_unit functional_unit_inst (
        .clock(clock),
        .reset(reset),
        .issue_in(issue_bus),
        .peek_opcode(alloc_opcode),
        .flush(flush),
        .fu_ready(fu_ready),
        .result_bus(result_bus)
    );

    retire_stage retire_stage_inst (
        .clock(clock),
        .reset(reset),
        .head(head),
        .retire_entry(retire_entry),
        .flush(flush),
        .commit_out(commit_out),
        .store_out(store_out),
        .flush_out(flush_out)
    );

endmodule

// File: retire_stage.sv
`timescale 1ns/1ps

module retire_stage (
    input logic clock,
    input logic reset,
    input ooo_pkg::head_packet_t head,
    output logic retire_entry,
    output logic flush,
    output ooo_pkg::commit_packet_t commit_out,
    output ooo_pkg::store_packet_t store_out,
    output logic flush_out
);

    // architectural state
    logic [ooo_pkg::data_bits-1:0] regfile [ooo_pkg::reg_count];

    logic head_writes;
    logic commit_fire;
    logic store_fire;
    logic reg_write;

    // registered outputs, valids under reset
    logic commit_valid;
    logic [ooo_pkg::reg_bits-1:0] commit_dest;
    logic commit_reg_valid;
    logic store_valid;
    logic [ooo_pkg::data_bits-1:0] store_addr;

    // alu and mul ops target the register file
    function automatic logic writes_register(input ooo_pkg::opcode_t op);
        return op inside {ooo_pkg::op_add, ooo_pkg::op_sub, ooo_pkg::op_and,
                          ooo_pkg::op_xor, ooo_pkg::op_mul};
    endfunction

    // one entry per cycle, straight from a ready head
    assign retire_entry = head.valid && head.ready;
    // trap retires and flushes on the same edge
    assign flush = retire_entry && (head.opcode == ooo_pkg::op_trap);

    assign head_writes = writes_register(head.opcode);
    assign commit_fire = retire_entry && head_writes;
    assign store_fire = retire_entry && (head.opcode == ooo_pkg::op_store);
    assign reg_write = commit_fire && (head.dest != ooo_pkg::zero_reg);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            commit_valid <= 1'b0;
            store_valid <= 1'b0;
            flush_out <= 1'b0;
        end else begin
            commit_valid <= commit_fire;
            store_valid <= store_fire;
            flush_out <= flush;
        end
    end

    always_ff @(posedge clock) begin
        if (commit_fire) begin
            commit_dest <= head.dest;
            commit_reg_valid <= (head.dest != ooo_pkg::zero_reg);
        end
        if (store_fire) begin
            store_addr <= head.value;
        end
        // r0 stays zero
        if (reg_write) begin
            regfile[head.dest] <= head.value;
        end
    end

    // commit shows what landed in the register file, r0 reads as zero
    always_comb begin
        commit_out.valid = commit_valid;
        commit_out.dest = commit_dest;
        commit_out.reg_valid = commit_reg_valid;
        commit_out.value = commit_reg_valid ? regfile[commit_dest] : '0;
        store_out.valid = store_valid;
        store_out.address = store_addr;
    end

endmodule

// File: functional_unit.sv
`timescale 1ns/1ps

module functional_unit (
    input logic clock,
    input logic reset,
    input ooo_pkg::issue_packet_t issue_in,
    // opcode at the dispatch queue front
    input ooo_pkg::opcode_t peek_opcode,
    input logic flush,
    output logic fu_ready,
    output ooo_pkg::result_packet_t result_bus
);

    localparam int last_slot = ooo_pkg::fu_slots - 1;

    // slot 0 is the mul entry point, the last slot drives the result bus
    logic [ooo_pkg::fu_slots-1:0] slot_valid;
    logic [ooo_pkg::rob_tag_bits-1:0] slot_tag [ooo_pkg::fu_slots];
    logic [ooo_pkg::data_bits-1:0] slot_value [ooo_pkg::fu_slots];

    logic issue_mul;
    logic issue_short;
    logic [ooo_pkg::data_bits-1:0] issue_value;

    // result computed at issue, then carried down the slots
    function automatic logic [ooo_pkg::data_bits-1:0] compute(
        input ooo_pkg::opcode_t op,
        input logic [ooo_pkg::data_bits-1:0] a,
        input logic [ooo_pkg::data_bits-1:0] b
    );
        logic [ooo_pkg::data_bits-1:0] res;
        case (op)
            ooo_pkg::op_add: res = a + b;
            ooo_pkg::op_sub: res = a - b;
            ooo_pkg::op_and: res = a & b;
            ooo_pkg::op_xor: res = a ^ b;
            // lower half of the product
            ooo_pkg::op_mul: res = a * b;
            // store value is its address
            ooo_pkg::op_store: res = a + b;
            default: res = '0;
        endcase
        return res;
    endfunction

    assign issue_mul = issue_in.valid && (issue_in.opcode == ooo_pkg::op_mul);
    assign issue_short = issue_in.valid && (issue_in.opcode != ooo_pkg::op_mul);
    assign issue_value = compute(issue_in.opcode, issue_in.operand_a, issue_in.operand_b);

    // short op lands in the last slot, which the slot before it refills
    // slot 0 empties every cycle so a mul always fits
    assign fu_ready = (peek_opcode == ooo_pkg::op_mul) || !slot_valid[last_slot-1];

    always_comb begin
        result_bus.valid = slot_valid[last_slot];
        result_bus.tag = slot_tag[last_slot];
        result_bus.value = slot_value[last_slot];
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            slot_valid <= '0;
        end else if (flush) begin
            // every in-flight result belongs to a flushed entry
            slot_valid <= '0;
        end else begin
            slot_valid <= {slot_valid[last_slot-1:0], issue_mul};
            if (issue_short) begin
                slot_valid[last_slot] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        slot_tag[0] <= issue_in.tag;
        slot_value[0] <= issue_value;
        for (int i = 1; i < ooo_pkg::fu_slots; i++) begin
            slot_tag[i] <= slot_tag[i-1];
            slot_value[i] <= slot_value[i-1];
        end
        if (issue_short) begin
            slot_tag[last_slot] <= issue_in.tag;
            slot_value[last_slot] <= issue_value;
        end
    end

endmodule

// File: dispatch_stage.sv
`timescale 1ns/1ps

module dispatch_stage (
    input logic clock,
    input logic reset,
    input ooo_pkg::instr_packet_t instr_in,
    output logic credit_return,
    input logic fu_ready,
    output logic alloc_req,
    output ooo_pkg::opcode_t alloc_opcode,
    output logic [ooo_pkg::reg_bits-1:0] alloc_dest,
    input logic alloc_grant,
    input logic [ooo_pkg::rob_tag_bits-1:0] alloc_tag,
    output ooo_pkg::issue_packet_t issue_out
);

    // instruction queue, sized to the credit pool
    ooo_pkg::instr_packet_t queue_mem [ooo_pkg::queue_depth];
    logic [ooo_pkg::queue_ptr_bits-1:0] rd_ptr;
    logic [ooo_pkg::queue_ptr_bits-1:0] wr_ptr;
    logic [ooo_pkg::credit_bits-1:0] count;

    ooo_pkg::instr_packet_t front;
    logic push;
    logic pop;

    assign front = queue_mem[rd_ptr];
    // source holds a credit for every valid beat, never refused
    assign push = instr_in.valid;
    assign pop = alloc_grant;

    // front entry asks for a tag only if the fu can take its opcode
    assign alloc_req = (count != '0) && fu_ready;
    assign alloc_opcode = front.opcode;
    assign alloc_dest = front.dest;

    // issue goes out in the grant cycle with the granted tag
    always_comb begin
        issue_out.valid = pop;
        issue_out.tag = alloc_tag;
        issue_out.opcode = front.opcode;
        issue_out.operand_a = front.operand_a;
        issue_out.operand_b = front.operand_b;
    end

    // one credit back per popped entry
    assign credit_return = pop;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            queue_mem[wr_ptr] <= instr_in;
        end
    end

endmodule

// File: reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
    input logic clock,
    input logic reset,
    // allocation from dispatch
    input logic alloc_req,
    input ooo_pkg::opcode_t alloc_opcode,
    input logic [ooo_pkg::reg_bits-1:0] alloc_dest,
    output logic alloc_grant,
    output logic [ooo_pkg::rob_tag_bits-1:0] alloc_tag,
    // completion from the functional unit
    input ooo_pkg::result_packet_t result_bus,
    // retire control
    input logic retire_entry,
    input logic flush,
    output ooo_pkg::head_packet_t head
);

    //////////////////////////////
    // storage
    //////////////////////////////

    // per-entry state, reset to empty
    ooo_pkg::entry_state_t entry_state [ooo_pkg::rob_size];
    // per-entry payload
    logic [ooo_pkg::data_bits-1:0] entry_value [ooo_pkg::rob_size];
    logic [ooo_pkg::reg_bits-1:0] entry_dest [ooo_pkg::rob_size];
    ooo_pkg::opcode_t entry_opcode [ooo_pkg::rob_size];

    // extra msb on each pointer tells full from empty
    logic [ooo_pkg::rob_tag_bits:0] head_ptr;
    logic [ooo_pkg::rob_tag_bits:0] tail_ptr;

    logic [ooo_pkg::rob_tag_bits-1:0] head_idx;
    logic [ooo_pkg::rob_tag_bits-1:0] tail_idx;
    logic rob_full;
    logic do_alloc;

    assign head_idx = head_ptr[ooo_pkg::rob_tag_bits-1:0];
    assign tail_idx = tail_ptr[ooo_pkg::rob_tag_bits-1:0];

    // same slot, opposite lap
    assign rob_full = (head_idx == tail_idx) &&
                      (head_ptr[ooo_pkg::rob_tag_bits] != tail_ptr[ooo_pkg::rob_tag_bits]);

    //////////////////////////////
    // allocation handshake
    //////////////////////////////

    // no allocation while the buffer is being flushed
    assign alloc_grant = alloc_req && !rob_full && !flush;
    assign do_alloc = alloc_grant;
    // the next free slot is always the tail
    assign alloc_tag = tail_idx;

    //////////////////////////////
    // head view for retire
    //////////////////////////////

    always_comb begin
        head.valid = (entry_state[head_idx] != ooo_pkg::st_empty);
        head.ready = (entry_state[head_idx] == ooo_pkg::st_ready);
        head.opcode = entry_opcode[head_idx];
        head.dest = entry_dest[head_idx];
        head.value = entry_value[head_idx];
    end

    //////////////////////////////
    // state and pointers
    //////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < ooo_pkg::rob_size; i++) begin
                entry_state[i] <= ooo_pkg::st_empty;
            end
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            // new instruction enters busy at the tail
            if (do_alloc) begin
                entry_state[tail_idx] <= ooo_pkg::st_busy;
                tail_ptr <= tail_ptr + 1'b1;
            end

            // completion, possibly out of order
            if (result_bus.valid) begin
                entry_state[result_bus.tag] <= ooo_pkg::st_ready;
            end

            // in-order retire of the head
            if (retire_entry) begin
                if (flush) begin
                    // trap retires and takes every younger entry with it
                    for (int i = 0; i < ooo_pkg::rob_size; i++) begin
                        entry_state[i] <= ooo_pkg::st_empty;
                    end
                    head_ptr <= tail_ptr;
                end else begin
                    entry_state[head_idx] <= ooo_pkg::st_empty;
                    head_ptr <= head_ptr + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // payload
    //////////////////////////////

    // state alone marks an entry live, payload needs no clear
    always_ff @(posedge clock) begin
        if (do_alloc) begin
            entry_opcode[tail_idx] <= alloc_opcode;
            entry_dest[tail_idx] <= alloc_dest;
        end
        if (result_bus.valid) begin
            entry_value[result_bus.tag] <= result_bus.value;
        end
    end

endmodule

// File: ooo_pkg.sv
package ooo_pkg;

    //////////////////////////////
    // sizes
    //////////////////////////////

    // reorder buffer depth and tag width
    localparam int rob_size = 8;
    localparam int rob_tag_bits = 3;

    // dispatch queue depth, also the credit count after reset
    localparam int queue_depth = 4;
    localparam int queue_ptr_bits = $clog2(queue_depth);
    // wide enough to count 0..queue_depth
    localparam int credit_bits = 3;

    // result pipeline slots in the functional unit
    localparam int fu_slots = 3;

    // architectural register file
    localparam int reg_count = 32;
    localparam int reg_bits = 5;
    localparam int data_bits = 32;
    localparam logic [reg_bits-1:0] zero_reg = '0;

    //////////////////////////////
    // encodings
    //////////////////////////////

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_mul,
        op_store,
        op_trap
    } opcode_t;

    typedef enum logic [1:0] {
        st_empty,
        st_busy,
        st_ready
    } entry_state_t;

    //////////////////////////////
    // packets
    //////////////////////////////

    // decoded instruction from the source, operands included
    typedef struct packed {
        logic valid;
        opcode_t opcode;
        logic [reg_bits-1:0] dest;
        logic [data_bits-1:0] operand_a;
        logic [data_bits-1:0] operand_b;
    } instr_packet_t;

    // dispatch to functional unit
    typedef struct packed {
        logic valid;
        logic [rob_tag_bits-1:0] tag;
        opcode_t opcode;
        logic [data_bits-1:0] operand_a;
        logic [data_bits-1:0] operand_b;
    } issue_packet_t;

    // single result bus back into the rob
    typedef struct packed {
        logic valid;
        logic [rob_tag_bits-1:0] tag;
        logic [data_bits-1:0] value;
    } result_packet_t;

    // rob head entry as seen by retire
    typedef struct packed {
        logic valid;
        logic ready;
        opcode_t opcode;
        logic [reg_bits-1:0] dest;
        logic [data_bits-1:0] value;
    } head_packet_t;

    typedef struct packed {
        logic valid;
        logic [reg_bits-1:0] dest;
        logic [data_bits-1:0] value;
        logic reg_valid;
    } commit_packet_t;

    typedef struct packed {
        logic valid;
        logic [data_bits-1:0] address;
    } store_packet_t;

endpackage
